/* bench/soc_tb_util.svh */
`ifndef SOC_TB_UTIL_SVH
`define SOC_TB_UTIL_SVH

logic [31:0] lcg_state = 32'h684b;

// classic 32-bit lcg step
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// expected read data from the address map and the pin models
function automatic logic [`ARCHBITSZ-1:0] ref_read(
	input logic [`ADDRBITSZ-1:0] addr,
	input logic [`GPIOCOUNT-1:0] gpo,
	input logic [`GPIOCOUNT-1:0] gpi
);
	logic [`OFFBITSZ-1:0]    off;
	logic [`SLVIDXBITSZ-1:0] idx;
	logic [`ARCHBITSZ-1:0]   rd;
	off = addr[`OFFBITSZ-1:0];
	idx = addr[`OFFBITSZ +: `SLVIDXBITSZ];
	rd = '0;
	if ((addr >> (`OFFBITSZ + `SLVIDXBITSZ)) != '0) begin
		rd = '0;
	end else if (idx == `SLVIDXBITSZ'(`SLV_DEVTBL)) begin
		case (off)
			`OFFBITSZ'(2 * `SLV_DEVTBL):     rd = `DEVID_DEVTBL;
			`OFFBITSZ'(2 * `SLV_DEVTBL + 1): rd = `MAPSZ_DEVTBL;
			`OFFBITSZ'(2 * `SLV_GPIO):       rd = `DEVID_GPIO;
			`OFFBITSZ'(2 * `SLV_GPIO + 1):   rd = `MAPSZ_GPIO;
			// the request register is back to none whenever the bus answers
			default:                         rd = '0;
		endcase
	end else if (idx == `SLVIDXBITSZ'(`SLV_GPIO)) begin
		if (off == `OFFBITSZ'(0))
			rd = {{(`ARCHBITSZ-`GPIOCOUNT){1'b0}}, gpi};
		else if (off == `OFFBITSZ'(1))
			rd = {{(`ARCHBITSZ-`GPIOCOUNT){1'b0}}, gpo};
	end
	return rd;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("error: %s is %h, expected %h", name, got, exp);
		stop_on_failure();
	end
endtask

`endif

/* bench/soc_tb.sv */
`include "soc_consts.svh"

module soc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic                  clk100mhz;
	logic                  rst_p;
	logic [1:0]            pi1_op_i;
	logic [`ADDRBITSZ-1:0] pi1_addr_i;
	logic [`ARCHBITSZ-1:0] pi1_data_i;
	logic [`ARCHBITSZ-1:0] pi1_data_o;
	logic                  pi1_rdy_o;
	logic [`GPIOCOUNT-1:0] gp_i;
	logic [`GPIOCOUNT-1:0] gp_o;
	logic                  sys_rst_o;

	// pin state as the reference function sees it
	logic [`GPIOCOUNT-1:0] gpo_model;
	logic [`GPIOCOUNT-1:0] gpi_model;
	logic [`ADDRBITSZ-1:0] rd_addr_q [$];
	logic [`ARCHBITSZ-1:0] rd_data_q [$];
	logic [`ARCHBITSZ-1:0] rd_exp_q [$];

	soc_top dut0 (.*);

	initial begin
		clk100mhz = 1'b0;
		forever #5 clk100mhz = ~clk100mhz;
	end

	task automatic stop_on_failure();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	`include "soc_tb_util.svh"

	// inputs change 1 ns after the rising edge
	task automatic next_slot();
		@(posedge clk100mhz);
		#1;
	endtask

	function automatic logic [`ADDRBITSZ-1:0] win_addr(input int high, input int idx, input int off);
		return {(`ADDRBITSZ-`SLVIDXBITSZ-`OFFBITSZ)'(high), `SLVIDXBITSZ'(idx), `OFFBITSZ'(off)};
	endfunction

	task automatic access_bus(input logic [1:0] op, input logic [`ADDRBITSZ-1:0] addr,
		input logic [`ARCHBITSZ-1:0] data, output logic [`ARCHBITSZ-1:0] rdata);
		int n;
		n = 0;
		pi1_op_i = op;
		pi1_addr_i = addr;
		pi1_data_i = data;
		next_slot();
		while (!pi1_rdy_o && (n < 20)) begin
			next_slot();
			n++;
		end
		if (!pi1_rdy_o) begin
			$display("bus access at address %h got no ready", addr);
			stop_on_failure();
		end
		rdata = pi1_data_o;
		// op back to noop so the router can go idle
		pi1_op_i = `PI1_NOOP;
		next_slot();
	endtask

	task automatic read_word(input logic [`ADDRBITSZ-1:0] addr);
		logic [`ARCHBITSZ-1:0] d;
		access_bus(`PI1_RDOP, addr, '0, d);
		rd_addr_q.push_back(addr);
		rd_data_q.push_back(d);
		// expected value from the pin models as they stand for this read
		rd_exp_q.push_back(ref_read(addr, gpo_model, gpi_model));
	endtask

	task automatic write_word(input logic [`ADDRBITSZ-1:0] addr, input logic [`ARCHBITSZ-1:0] data);
		logic [`ARCHBITSZ-1:0] d;
		access_bus(`PI1_WROP, addr, data, d);
	endtask

	task automatic wait_for_sys_rst(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while ((sys_rst_o !== level) && (n < limit)) begin
			next_slot();
			n++;
		end
		if (sys_rst_o !== level) begin
			$display("timeout while waiting for %s", what);
			stop_on_failure();
		end
	endtask

	// compares every read against the reference
	initial begin
		logic [`ADDRBITSZ-1:0] addr;
		logic [`ARCHBITSZ-1:0] data;
		logic [`ARCHBITSZ-1:0] exp_data;
		forever begin
			@(posedge clk100mhz);
			while (rd_addr_q.size() > 0) begin
				addr = rd_addr_q.pop_front();
				data = rd_data_q.pop_front();
				exp_data = rd_exp_q.pop_front();
				check_value($sformatf("pi1_data_o at %h", addr), data, exp_data);
			end
		end
	end

	initial begin
		logic [`ARCHBITSZ-1:0] rnd;
		int cnt;
		rst_p = 1'b1;
		pi1_op_i = `PI1_NOOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		gp_i = '0;
		gpo_model = '0;
		gpi_model = '0;
		repeat (5) next_slot();
		rst_p = 1'b0;

		// release count after the external reset
		cnt = 0;
		while (sys_rst_o && (cnt < 100)) begin
			check_value("pi1_rdy_o", 32'(pi1_rdy_o), 32'd0);
			check_value("gp_o", 32'(gp_o), 32'd0);
			next_slot();
			cnt++;
		end
		check_value("sys_rst_o high cycles", 32'(cnt), 32'd15);

		for (int k = 0; k < 4; k++)
			read_word(win_addr(0, `SLV_DEVTBL, k));

		for (int k = 0; k < 8; k++) begin
			rnd = lcg_next();
			write_word(win_addr(0, `SLV_GPIO, 1), rnd);
			gpo_model = rnd[`GPIOCOUNT-1:0];
			check_value("gp_o", 32'(gp_o), 32'(gpo_model));
			read_word(win_addr(0, `SLV_GPIO, 1));
			rnd = lcg_next();
			gp_i = rnd[8 +: `GPIOCOUNT];
			gpi_model = rnd[8 +: `GPIOCOUNT];
			// two synchronizer edges
			repeat (2) next_slot();
			read_word(win_addr(0, `SLV_GPIO, 0));
		end

		// unmapped windows and a nonzero high part
		rnd = lcg_next();
		read_word(win_addr(0, 2, 1));
		read_word(win_addr(0, 3, 0));
		read_word(win_addr((rnd >> 14) | 32'd1, `SLV_GPIO, 1));
		write_word(win_addr(0, 2, 1), lcg_next());
		write_word(win_addr(0, 3, 1), lcg_next());
		write_word(win_addr(1, `SLV_GPIO, 1), 32'(~gpo_model));
		check_value("gp_o", 32'(gp_o), 32'(gpo_model));
		read_word(win_addr(0, `SLV_GPIO, 1));

		// warm first, then cold
		for (int k = 0; k < 2; k++) begin
			rnd = lcg_next();
			gpo_model = rnd[`GPIOCOUNT-1:0] | `GPIOCOUNT'(1);
			write_word(win_addr(0, `SLV_GPIO, 1), 32'(gpo_model));
			write_word(win_addr(0, `SLV_DEVTBL, `DEVTBL_RST_OFF),
				32'((k == 0) ? `RST_REQ_WARM : `RST_REQ_COLD));
			wait_for_sys_rst(1'b1, 10, "software reset to rise");
			next_slot();
			check_value("gp_o", 32'(gp_o), 32'd0);
			gpo_model = '0;
			wait_for_sys_rst(1'b0, 40, "software reset to release");
			read_word(win_addr(0, `SLV_GPIO, 1));
		end

		// outputs set again so the power-off reset has something to clear
		rnd = lcg_next();
		gpo_model = rnd[`GPIOCOUNT-1:0] | `GPIOCOUNT'(1);
		write_word(win_addr(0, `SLV_GPIO, 1), 32'(gpo_model));
		write_word(win_addr(0, `SLV_DEVTBL, `DEVTBL_RST_OFF), 32'(`RST_REQ_PWROFF));
		wait_for_sys_rst(1'b1, 10, "power-off reset to rise");
		// held well past the release timeout
		repeat (50) begin
			next_slot();
			check_value("sys_rst_o", 32'(sys_rst_o), 32'd1);
		end
		rst_p = 1'b1;
		next_slot();
		rst_p = 1'b0;
		wait_for_sys_rst(1'b0, 40, "release after the external reset pulse");
		gpo_model = '0;
		read_word(win_addr(0, `SLV_GPIO, 1));
		read_word(win_addr(0, `SLV_DEVTBL, 0));

		cnt = 0;
		while ((rd_addr_q.size() > 0) && (cnt < 4)) begin
			next_slot();
			cnt++;
		end
		if (rd_addr_q.size() == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("reads were left unchecked at the end of the run");
			stop_on_failure();
		end
	end

endmodule

/* filelist.f */
+incdir+hw
+incdir+bench
hw/soc_pkg.sv
hw/reset_seq.sv
hw/pi1_router.sv
hw/dev_table.sv
hw/gpio_port.sv
hw/soc_top.sv
bench/soc_tb.sv

/* hw/dev_table.sv */
`include "soc_consts.svh"

module dev_table import soc_pkg::*; (
	input  logic                  clk100mhz,
	input  logic                  sys_rst_i,
	input  logic [1:0]            op_i,
	input  pi1_addr_u             off_i,
	input  logic [`ARCHBITSZ-1:0] data_i,
	output logic [`ARCHBITSZ-1:0] data_o,
	output logic                  rdy_o,
	output logic [1:0]            rst_req_o
);

	// one entry per slave index
	localparam logic [`ARCHBITSZ-1:0] DEV_ID [`SLVCOUNT] = '{
		`SLV_DEVTBL: `DEVID_DEVTBL,
		`SLV_GPIO:   `DEVID_GPIO
	};
	localparam logic [`ARCHBITSZ-1:0] DEV_MAPSZ [`SLVCOUNT] = '{
		`SLV_DEVTBL: `MAPSZ_DEVTBL,
		`SLV_GPIO:   `MAPSZ_GPIO
	};

	logic [`OFFBITSZ-1:0]  off_w;
	logic [`ARCHBITSZ-1:0] rd_w;
	logic [1:0]            rst_req_q;

	assign off_w = off_i.f.off;

	// even word is the id, odd word the map size
	always_comb begin
		rd_w = '0;
		for (int k = 0; k < `SLVCOUNT; k++) begin
			if (off_w == `OFFBITSZ'(2 * k))
				rd_w = DEV_ID[k];
			if (off_w == `OFFBITSZ'(2 * k + 1))
				rd_w = DEV_MAPSZ[k];
		end
		if (off_w == `DEVTBL_RST_OFF)
			rd_w = {{(`ARCHBITSZ-2){1'b0}}, rst_req_q};
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rdy_o     <= 1'b0;
			rst_req_q <= `RST_REQ_NONE;
		end else begin
			rdy_o <= (op_i != `PI1_NOOP);
			if ((op_i == `PI1_WROP) && (off_w == `DEVTBL_RST_OFF))
				rst_req_q <= data_i[1:0];
		end
	end

	always_ff @(posedge clk100mhz) begin
		data_o <= (op_i == `PI1_RDOP) ? rd_w : '0;
	end

	assign rst_req_o = rst_req_q;

	// router forwards each request for one cycle, so ready never stretches
	a_rdy_pulse: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		rdy_o |=> !rdy_o);

endmodule

/* hw/gpio_port.sv */
`include "soc_consts.svh"

module gpio_port import soc_pkg::*; (
	input  logic                  clk100mhz,
	input  logic                  sys_rst_i,
	input  logic [1:0]            op_i,
	input  pi1_addr_u             off_i,
	input  logic [`ARCHBITSZ-1:0] data_i,
	output logic [`ARCHBITSZ-1:0] data_o,
	output logic                  rdy_o,
	input  logic [`GPIOCOUNT-1:0] gp_i,
	output logic [`GPIOCOUNT-1:0] gp_o
);

	localparam logic [`OFFBITSZ-1:0] IN_OFF  = 'd0;
	localparam logic [`OFFBITSZ-1:0] OUT_OFF = 'd1;

	logic [`GPIOCOUNT-1:0] sync1_q;
	logic [`GPIOCOUNT-1:0] sync2_q;
	logic [`GPIOCOUNT-1:0] out_q;
	logic [`ARCHBITSZ-1:0] rd_w;

	// pins are asynchronous to the bus
	always_ff @(posedge clk100mhz) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
	end

	always_comb begin
		case (off_i.f.off)
			IN_OFF:  rd_w = {{(`ARCHBITSZ-`GPIOCOUNT){1'b0}}, sync2_q};
			OUT_OFF: rd_w = {{(`ARCHBITSZ-`GPIOCOUNT){1'b0}}, out_q};
			default: rd_w = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rdy_o <= 1'b0;
			out_q <= '0;
		end else begin
			rdy_o <= (op_i != `PI1_NOOP);
			if ((op_i == `PI1_WROP) && (off_i.f.off == OUT_OFF))
				out_q <= data_i[`GPIOCOUNT-1:0];
		end
	end

	always_ff @(posedge clk100mhz) begin
		data_o <= (op_i == `PI1_RDOP) ? rd_w : '0;
	end

	assign gp_o = out_q;

endmodule

/* hw/pi1_router.sv */
`include "soc_consts.svh"

module pi1_router import soc_pkg::*; (
	input  logic                  clk100mhz,
	input  logic                  sys_rst_i,
	input  logic [1:0]            m_op_i,
	input  pi1_addr_u             m_addr_i,
	input  logic [`ARCHBITSZ-1:0] m_data_i,
	output logic [`ARCHBITSZ-1:0] m_data_o,
	output logic                  m_rdy_o,
	output logic [1:0]            s_op_o [`SLVCOUNT],
	output pi1_addr_u             s_off_o,
	output logic [`ARCHBITSZ-1:0] s_data_o,
	input  logic [`ARCHBITSZ-1:0] s_data_i [`SLVCOUNT],
	input  logic [`SLVCOUNT-1:0]  s_rdy_i
);

	localparam int SELBITSZ = $clog2(`SLVCOUNT);

	logic                busy_q;
	logic                inv_q;
	logic                inv_rdy_q;
	logic [SELBITSZ-1:0] sel_q;
	logic                accept_w;
	logic                invalid_w;

	// new request only from idle
	assign accept_w = !busy_q && (m_op_i != `PI1_NOOP);
	assign invalid_w = (m_addr_i.f.high != '0) || (m_addr_i.f.idx >= `SLVCOUNT);

	// op goes to the selected slave for the accepting cycle only
	always_comb begin
		for (int k = 0; k < `SLVCOUNT; k++) begin
			s_op_o[k] = `PI1_NOOP;
			if (accept_w && !invalid_w && (m_addr_i.f.idx == k))
				s_op_o[k] = m_op_i;
		end
	end

	// slaves see an address local to their window
	always_comb begin
		s_off_o.raw = '0;
		s_off_o.f.off = m_addr_i.f.off;
	end

	assign s_data_o = m_data_i;

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			busy_q    <= 1'b0;
			inv_q     <= 1'b0;
			inv_rdy_q <= 1'b0;
			sel_q     <= '0;
		end else begin
			// invalid device answers by itself with zero data
			inv_rdy_q <= accept_w && invalid_w;
			if (accept_w) begin
				busy_q <= 1'b1;
				inv_q  <= invalid_w;
				sel_q  <= m_addr_i.f.idx[SELBITSZ-1:0];
			end else if (m_op_i == `PI1_NOOP) begin
				busy_q <= 1'b0;
			end
		end
	end

	assign m_rdy_o  = inv_q ? inv_rdy_q : s_rdy_i[sel_q];
	assign m_data_o = inv_q ? '0 : s_data_i[sel_q];

	a_one_rdy: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		$onehot0({inv_rdy_q, s_rdy_i}));

	a_rdy_busy: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		m_rdy_o |-> busy_q);

endmodule

/* hw/reset_seq.sv */
`include "soc_consts.svh"

module reset_seq (
	input  logic       clk100mhz,
	input  logic       rst_p,
	input  logic [1:0] rst_req_i,
	output logic       sys_rst_o
);

	logic [`RST_CNTR_BITSZ-1:0] cntr_q;
	logic                       pwroff_q;
	logic                       sw_cold_w;
	logic                       sw_warm_w;
	logic                       sw_pwroff_w;

	assign sw_cold_w   = (rst_req_i == `RST_REQ_COLD);
	assign sw_warm_w   = (rst_req_i == `RST_REQ_WARM);
	assign sw_pwroff_w = (rst_req_i == `RST_REQ_PWROFF);

	// cold restarts the count the same way warm does
	always_ff @(posedge clk100mhz) begin
		if (rst_p || sw_cold_w || sw_warm_w) begin
			cntr_q <= '1;
		end else if (cntr_q != '0) begin
			cntr_q <= cntr_q - 1'b1;
		end
	end

	// power-off holds the system down until the board reset
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff_w) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (cntr_q != '0) || pwroff_q;

	a_cntr_step: assert property (@(posedge clk100mhz) disable iff (rst_p)
		(cntr_q != $past(cntr_q)) |-> ((cntr_q == '1) || (cntr_q == $past(cntr_q) - 1'b1)));

endmodule

/* hw/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// bus widths
`define ARCHBITSZ 32
`define ADDRBITSZ 30
`define OFFBITSZ 10
`define SLVIDXBITSZ 2

// pi1 op codes
`define PI1_NOOP 2'd0
`define PI1_RDOP 2'd1
`define PI1_WROP 2'd2

// slave map, every window is 4 KB
`define SLV_DEVTBL 0
`define SLV_GPIO 1
`define SLVCOUNT 2

`define DEVID_DEVTBL 7
`define DEVID_GPIO 6
`define MAPSZ_DEVTBL 'h1000
`define MAPSZ_GPIO 'h1000

// software reset request register and its codes
`define DEVTBL_RST_OFF 'h3ff
`define RST_REQ_NONE 2'd0
`define RST_REQ_PWROFF 2'd1
`define RST_REQ_WARM 2'd2
`define RST_REQ_COLD 2'd3
`define RST_CNTR_BITSZ 4

`define GPIOCOUNT 8

`endif

/* hw/soc_pkg.sv */
`include "soc_consts.svh"

package soc_pkg;

	// word address, either whole or split into its window fields
	typedef union packed {
		logic [`ADDRBITSZ-1:0] raw;
		struct packed {
			// nonzero here means no device
			logic [`ADDRBITSZ-`SLVIDXBITSZ-`OFFBITSZ-1:0] high;
			logic [`SLVIDXBITSZ-1:0]                      idx;
			logic [`OFFBITSZ-1:0]                         off;
		} f;
	} pi1_addr_u;

endpackage

/* hw/soc_top.sv */
`include "soc_consts.svh"

module soc_top import soc_pkg::*; (
	input  logic                  clk100mhz,
	input  logic                  rst_p,
	input  logic [1:0]            pi1_op_i,
	input  logic [`ADDRBITSZ-1:0] pi1_addr_i,
	input  logic [`ARCHBITSZ-1:0] pi1_data_i,
	output logic [`ARCHBITSZ-1:0] pi1_data_o,
	output logic                  pi1_rdy_o,
	input  logic [`GPIOCOUNT-1:0] gp_i,
	output logic [`GPIOCOUNT-1:0] gp_o,
	output logic                  sys_rst_o
);

	logic [1:0]            rst_req_w;
	logic [1:0]            s_op_w [`SLVCOUNT];
	pi1_addr_u             s_off_w;
	logic [`ARCHBITSZ-1:0] s_wdata_w;
	logic [`ARCHBITSZ-1:0] s_rdata_w [`SLVCOUNT];
	logic [`SLVCOUNT-1:0]  s_rdy_w;

	// system reset also leaves the chip, as it once did for the sd card
	reset_seq u_reset_seq (
		.clk100mhz (clk100mhz),
		.rst_p     (rst_p),
		.rst_req_i (rst_req_w),
		.sys_rst_o (sys_rst_o)
	);

	pi1_router u_router (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst_o),
		.m_op_i    (pi1_op_i),
		.m_addr_i  (pi1_addr_i),
		.m_data_i  (pi1_data_i),
		.m_data_o  (pi1_data_o),
		.m_rdy_o   (pi1_rdy_o),
		.s_op_o    (s_op_w),
		.s_off_o   (s_off_w),
		.s_data_o  (s_wdata_w),
		.s_data_i  (s_rdata_w),
		.s_rdy_i   (s_rdy_w)
	);

	dev_table u_dev_table (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst_o),
		.op_i      (s_op_w[`SLV_DEVTBL]),
		.off_i     (s_off_w),
		.data_i    (s_wdata_w),
		.data_o    (s_rdata_w[`SLV_DEVTBL]),
		.rdy_o     (s_rdy_w[`SLV_DEVTBL]),
		.rst_req_o (rst_req_w)
	);

	gpio_port u_gpio (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst_o),
		.op_i      (s_op_w[`SLV_GPIO]),
		.off_i     (s_off_w),
		.data_i    (s_wdata_w),
		.data_o    (s_rdata_w[`SLV_GPIO]),
		.rdy_o     (s_rdy_w[`SLV_GPIO]),
		.gp_i      (gp_i),
		.gp_o      (gp_o)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module soc_tb -f filelist.f -Mdir obj_dir -o soc_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/soc_tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
